// File: sim.f
+incdir+include
hw/core_pkg.sv
hw/register_file.sv
hw/forward_select.sv
hw/decode.sv
hw/decode_stage.sv
verification/decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' sim.f) $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) sim.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb
    import core_pkg::*;
;

    localparam int stim_cycles = 120;

    typedef struct packed {
        op_t   op;
        fn_t   fn;
        br_t   br;
        word_t pc;
        word_t op1;
        word_t op2;
        word_t rs1;
        word_t rs2;
        addr_t rd;
        logic  op1_care;
        logic  op2_care;
    } exp_t;

    logic  sink;
    logic  reset;
    logic  in_valid;
    logic  in_ready;
    word_t in_pc;
    inst_t in_inst;
    logic  ex_valid;
    logic  ex_ready;
    op_t   ex_op;
    fn_t   ex_fn;
    br_t   ex_br;
    word_t ex_pc;
    word_t ex_op1;
    word_t ex_op2;
    word_t ex_rs1;
    word_t ex_rs2;
    addr_t ex_rd;
    addr_t alu_rd;
    logic  alu_wen;
    logic  alu_load;
    word_t alu_data;
    addr_t exe_rd;
    logic  exe_wen;
    word_t exe_data;
    addr_t mem_rd;
    logic  mem_wen;
    word_t mem_data;
    logic  wb_en;
    addr_t wb_addr;
    word_t wb_data;
    logic  invalid;

    integer seed = 32'he2fab154;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     test_errors0 = 0;
    string  test_name = "reset";
    word_t  model_regs [0:31];
    exp_t   exp_q [$];
    exp_t   head;
    logic   have = 1'b0;
    logic   pop_pending = 1'b0;
    word_t  pc = 32'h0000_1000;

    decode_stage decode_stage_i (.*);

    always #5 sink = ~sink;

    // Reference model built from the RV32I encoding
    function automatic op_t ref_op(inst_t inst);
        logic [2:0] f3;
        f3 = inst[14:12];
        case (inst[6:0])
            OPCODE_OP_IMM, OPCODE_OP, OPCODE_LUI, OPCODE_AUIPC: return INTEGER;
            OPCODE_JAL, OPCODE_JALR: return JUMP;
            OPCODE_BRANCH: return (f3 == 3'd2 || f3 == 3'd3) ? NONE : BRANCH;
            OPCODE_LOAD: begin
                case (f3)
                    3'd0:    return LOAD_BYTE;
                    3'd1:    return LOAD_HALF;
                    3'd2:    return LOAD_WORD;
                    3'd4:    return LOAD_BYTE_UNSIGNED;
                    3'd5:    return LOAD_HALF_UNSIGNED;
                    default: return NONE;
                endcase
            end
            OPCODE_STORE: begin
                case (f3)
                    3'd0:    return STORE_BYTE;
                    3'd1:    return STORE_HALF;
                    3'd2:    return STORE_WORD;
                    default: return NONE;
                endcase
            end
            default: return NONE;
        endcase
    endfunction

    function automatic fn_t ref_fn(inst_t inst);
        logic [6:0] opc;
        opc = inst[6:0];
        if (ref_op(inst) == NONE) return ANY;
        if (opc == OPCODE_LUI) return OP2;
        if (opc != OPCODE_OP && opc != OPCODE_OP_IMM) return ADD;
        case (inst[14:12])
            3'd0:    return (opc == OPCODE_OP && inst[30]) ? SUB : ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return inst[30] ? SRA : SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    function automatic br_t ref_br(inst_t inst);
        if (ref_op(inst) == JUMP) return JAL;
        if (ref_op(inst) != BRANCH) return NA;
        case (inst[14:12])
            3'd0:    return BEQ;
            3'd1:    return BNE;
            3'd4:    return BLT;
            3'd5:    return BGE;
            3'd6:    return BLTU;
            default: return BGEU;
        endcase
    endfunction

    function automatic word_t ref_op2(inst_t inst, word_t rs2);
        case (inst[6:0])
            OPCODE_OP: return rs2;
            OPCODE_STORE: return {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OPCODE_BRANCH:
                return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OPCODE_LUI, OPCODE_AUIPC: return {inst[31:12], 12'h000};
            OPCODE_JAL:
                return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: return {{20{inst[31]}}, inst[31:20]};
        endcase
    endfunction

    // Nearest later stage wins
    function automatic word_t fwd(addr_t a);
        if (a == 5'd0) return '0;
        if (alu_wen && alu_rd == a) return alu_data;
        if (exe_wen && exe_rd == a) return exe_data;
        if (mem_wen && mem_rd == a) return mem_data;
        return model_regs[a];
    endfunction

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, addr_t rs2, addr_t rs1, logic [2:0] f3,
                                    addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, addr_t rs1, logic [2:0] f3, addr_t rd,
                                    logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_s(logic [11:0] imm, addr_t rs2, addr_t rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
    endfunction

    function automatic inst_t enc_b(logic [12:0] off, addr_t rs2, addr_t rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
    endfunction

    function automatic inst_t enc_j(logic [20:0] off, addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
    endfunction

    task automatic push_expected(inst_t inst, word_t ipc);
        exp_t       e;
        logic [6:0] opc;
        opc = inst[6:0];
        e.op  = ref_op(inst);
        e.fn  = ref_fn(inst);
        e.br  = ref_br(inst);
        e.pc  = ipc;
        e.rs1 = fwd(inst[19:15]);
        e.rs2 = fwd(inst[24:20]);
        e.rd  = inst[11:7];
        e.op1_care = e.op != NONE && opc != OPCODE_LUI;
        e.op1 = (opc == OPCODE_AUIPC || opc == OPCODE_JAL || opc == OPCODE_BRANCH)
            ? ipc : e.rs1;
        e.op2_care = e.op != NONE;
        e.op2 = ref_op2(inst, e.rs2);
        exp_q.push_back(e);
        head = exp_q[0];
        have = 1'b1;
    endtask

    // Tasks start and end on a falling edge
    task automatic send(inst_t inst);
        in_valid = 1'b1;
        in_inst  = inst;
        in_pc    = pc;
        #1;
        while (!in_ready) begin
            @(negedge sink);
            #1;
        end
        push_expected(inst, pc);
        pc = pc + 32'd4;
        @(negedge sink);
        in_valid = 1'b0;
    endtask

    task automatic writeback(addr_t a, word_t d);
        wb_en   = 1'b1;
        wb_addr = a;
        wb_data = d;
        @(negedge sink);
        wb_en = 1'b0;
        if (a != 5'd0) model_regs[a] = d;
    endtask

    task automatic clear_pipeline();
        alu_wen  = 1'b0;
        alu_load = 1'b0;
        exe_wen  = 1'b0;
        mem_wen  = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || pop_pending) && n < 100) begin
            @(negedge sink);
            n++;
        end
        if (n == 100) begin
            errors++;
            $display("%s: expected instructions never left the stage", test_name);
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errors0 = errors;
    endtask

    task automatic finish_test();
        drain();
        tests_run++;
        if (errors != test_errors0) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_errors0);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    always @(posedge sink) begin
        if (!reset && ex_valid && ex_ready) pop_pending = 1'b1;
    end

    always @(negedge sink) begin
        if (pop_pending) begin
            pop_pending = 1'b0;
            if (exp_q.size() != 0) void'(exp_q.pop_front());
            have = exp_q.size() != 0;
            if (have) head = exp_q[0];
        end
    end

    transfer_matches: assert property (
        @(posedge sink) disable iff (reset)
        ex_valid && ex_ready |-> have && ex_op == head.op && ex_fn == head.fn
            && ex_br == head.br && ex_pc == head.pc && ex_rs1 == head.rs1
            && ex_rs2 == head.rs2 && ex_rd == head.rd
            && (!head.op1_care || ex_op1 == head.op1)
            && (!head.op2_care || ex_op2 == head.op2)
    ) else begin
        errors++;
        if (!have) begin
            $display("%s: the DUT delivered an instruction that was never accepted",
                test_name);
        end else begin
            $write("FAILED %s: expected op=%0d fn=%0d br=%0d pc=%h op1=%h op2=%h",
                test_name, head.op, head.fn, head.br, head.pc, head.op1, head.op2);
            $write(" rs1=%h rs2=%h rd=%0d,", head.rs1, head.rs2, head.rd);
            $write(" actual op=%0d fn=%0d br=%0d pc=%h op1=%h op2=%h",
                $sampled(ex_op), $sampled(ex_fn), $sampled(ex_br), $sampled(ex_pc),
                $sampled(ex_op1), $sampled(ex_op2));
            $display(" rs1=%h rs2=%h rd=%0d", $sampled(ex_rs1), $sampled(ex_rs2),
                $sampled(ex_rd));
        end
    end

    load_use_blocks: assert property (
        @(posedge sink) disable iff (reset)
        alu_load && alu_wen && alu_rd != 5'd0
            && (alu_rd == in_inst[19:15] || alu_rd == in_inst[24:20]) |-> !in_ready
    ) else begin
        errors++;
        $display("%s: in_ready was high during a load-use hazard", test_name);
    end

    invalid_flag: assert property (
        @(posedge sink) disable iff (reset)
        in_valid |-> invalid == (ref_op(in_inst) == NONE)
    ) else begin
        errors++;
        $display("FAILED %s: expected invalid=%0d, actual invalid=%0d", test_name,
            ref_op($sampled(in_inst)) == NONE, $sampled(invalid));
    end

    held_outputs: assert property (
        @(posedge sink) disable iff (reset)
        ex_valid && !ex_ready |=> ex_valid && $stable(ex_op) && $stable(ex_fn)
            && $stable(ex_br) && $stable(ex_pc) && $stable(ex_op1) && $stable(ex_op2)
            && $stable(ex_rs1) && $stable(ex_rs2) && $stable(ex_rd)
    ) else begin
        errors++;
        $display("%s: outputs changed while ex_ready was low", test_name);
    end

    initial begin
        #(stim_cycles * 20 * 10);
        $display("Watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        sink = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_inst = '0;
        ex_ready = 1'b1;
        alu_rd = '0;
        alu_data = '0;
        exe_rd = '0;
        exe_data = '0;
        mem_rd = '0;
        mem_data = '0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        clear_pipeline();
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (4) @(negedge sink);
        reset = 1'b0;

        start_test("immediates");
        send(enc_i(12'(rand_word() >> 20), 5'd1, 3'd0, 5'd5, OPCODE_OP_IMM));
        send(enc_i({7'b0100000, 5'd5}, 5'd2, 3'd5, 5'd6, OPCODE_OP_IMM));
        send({20'(rand_word() >> 12), 5'd7, OPCODE_LUI});
        send({20'(rand_word() >> 12), 5'd8, OPCODE_AUIPC});
        finish_test();

        start_test("register_ops");
        writeback(5'd1, rand_word());
        writeback(5'd2, rand_word());
        writeback(5'd0, rand_word());
        send(enc_r(7'b0000000, 5'd2, 5'd1, 3'd0, 5'd3));
        send(enc_r(7'b0100000, 5'd2, 5'd1, 3'd0, 5'd3));
        send(enc_r(7'b0100000, 5'd2, 5'd1, 3'd5, 5'd4));
        send(enc_r(7'b0000000, 5'd2, 5'd0, 3'd0, 5'd4));
        finish_test();

        start_test("forwarding");
        mem_rd = 5'd1;
        mem_wen = 1'b1;
        mem_data = rand_word();
        exe_rd = 5'd1;
        exe_wen = 1'b1;
        exe_data = rand_word();
        alu_rd = 5'd1;
        alu_wen = 1'b1;
        alu_data = rand_word();
        send(enc_r(7'b0000000, 5'd1, 5'd1, 3'd0, 5'd9));
        alu_wen = 1'b0;
        send(enc_r(7'b0000000, 5'd1, 5'd1, 3'd0, 5'd9));
        exe_rd = 5'd2;
        send(enc_r(7'b0000000, 5'd2, 5'd1, 3'd0, 5'd9));
        // Zero destination must read as x0
        alu_rd = 5'd0;
        alu_wen = 1'b1;
        exe_rd = 5'd0;
        mem_rd = 5'd0;
        send(enc_r(7'b0000000, 5'd0, 5'd0, 3'd0, 5'd9));
        clear_pipeline();
        finish_test();

        start_test("control_flow_memory");
        send(enc_b(13'(rand_word() >> 19), 5'd2, 5'd1, 3'd0));
        send(enc_b(13'(rand_word() >> 19), 5'd2, 5'd1, 3'd6));
        send(enc_j(21'(rand_word() >> 11), 5'd1));
        send(enc_i(12'(rand_word() >> 20), 5'd2, 3'd0, 5'd1, OPCODE_JALR));
        send(enc_i(12'(rand_word() >> 20), 5'd1, 3'd2, 5'd10, OPCODE_LOAD));
        send(enc_i(12'(rand_word() >> 20), 5'd1, 3'd4, 5'd10, OPCODE_LOAD));
        send(enc_s(12'(rand_word() >> 20), 5'd2, 5'd1, 3'd2));
        send(enc_s(12'(rand_word() >> 20), 5'd2, 5'd1, 3'd0));
        finish_test();

        start_test("load_use_stall");
        alu_rd = 5'd3;
        alu_wen = 1'b1;
        alu_load = 1'b1;
        alu_data = rand_word();
        in_valid = 1'b1;
        in_inst = enc_r(7'b0000000, 5'd1, 5'd3, 3'd0, 5'd9);
        in_pc = pc;
        repeat (4) @(negedge sink);
        alu_load = 1'b0;
        send(enc_r(7'b0000000, 5'd1, 5'd3, 3'd0, 5'd9));
        clear_pipeline();
        finish_test();

        start_test("back_pressure");
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    send(enc_r(7'b0000000, 5'(i + 1), 5'(i + 2), 3'd0, 5'd11));
                end
            end
            begin
                repeat (14) begin
                    @(negedge sink);
                    ex_ready = 1'(rand_word() >> 31);
                end
                ex_ready = 1'b1;
            end
        join
        finish_test();

        start_test("invalid");
        send(32'h0000_0073);
        send(enc_b(13'h010, 5'd2, 5'd1, 3'd2));
        send(enc_i(12'h004, 5'd1, 3'd3, 5'd4, OPCODE_LOAD));
        send(enc_s(12'h008, 5'd2, 5'd1, 3'd4));
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
            errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import core_pkg::*;
(
    input  wire logic  sink,
    input  wire logic  reset,
    input  wire logic  in_valid,
    output logic       in_ready,
    input  wire word_t in_pc,
    input  wire inst_t in_inst,
    output logic       ex_valid,
    input  wire logic  ex_ready,
    output op_t        ex_op,
    output fn_t        ex_fn,
    output br_t        ex_br,
    output word_t      ex_pc,
    output word_t      ex_op1,
    output word_t      ex_op2,
    output word_t      ex_rs1,
    output word_t      ex_rs2,
    output addr_t      ex_rd,
    input  wire addr_t alu_rd,
    input  wire logic  alu_wen,
    input  wire logic  alu_load,
    input  wire word_t alu_data,
    input  wire addr_t exe_rd,
    input  wire logic  exe_wen,
    input  wire word_t exe_data,
    input  wire addr_t mem_rd,
    input  wire logic  mem_wen,
    input  wire word_t mem_data,
    input  wire logic  wb_en,
    input  wire addr_t wb_addr,
    input  wire word_t wb_data,
    output logic       invalid
);

    addr_t rs1_addr;
    addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    rs_t   rs1_sel;
    rs_t   rs2_sel;
    logic  stall;

    register_file register_file_i (
        .sink     (sink),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    forward_select forward_select_i (
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .alu_rd   (alu_rd),
        .exe_rd   (exe_rd),
        .mem_rd   (mem_rd),
        .alu_wen  (alu_wen),
        .exe_wen  (exe_wen),
        .mem_wen  (mem_wen),
        .alu_load (alu_load),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .stall    (stall)
    );

    decode decode_i (
        .sink     (sink),
        .reset    (reset),
        .stall    (stall),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .alu_data (alu_data),
        .exe_data (exe_data),
        .mem_data (mem_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .invalid  (invalid),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_pc    (in_pc),
        .in_inst  (in_inst),
        .ex_valid (ex_valid),
        .ex_ready (ex_ready),
        .ex_op    (ex_op),
        .ex_fn    (ex_fn),
        .ex_br    (ex_br),
        .ex_pc    (ex_pc),
        .ex_op1   (ex_op1),
        .ex_op2   (ex_op2),
        .ex_rs1   (ex_rs1),
        .ex_rs2   (ex_rs2),
        .ex_rd    (ex_rd)
    );

endmodule

`default_nettype wire

// File: hw/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode
    import core_pkg::*;
(
    input  wire logic  sink,
    input  wire logic  reset,
    input  wire logic  stall,
    input  wire rs_t   rs1_sel,
    input  wire rs_t   rs2_sel,
    input  wire word_t alu_data,
    input  wire word_t exe_data,
    input  wire word_t mem_data,
    input  wire word_t rs1_data,
    input  wire word_t rs2_data,
    output addr_t      rs1_addr,
    output addr_t      rs2_addr,
    output logic       invalid,
    input  wire logic  in_valid,
    output logic       in_ready,
    input  wire word_t in_pc,
    input  wire inst_t in_inst,
    output logic       ex_valid,
    input  wire logic  ex_ready,
    output op_t        ex_op,
    output fn_t        ex_fn,
    output br_t        ex_br,
    output word_t      ex_pc,
    output word_t      ex_op1,
    output word_t      ex_op2,
    output word_t      ex_rs1,
    output word_t      ex_rs2,
    output addr_t      ex_rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    op_t        ctl_op;
    fn_t        ctl_fn;
    br_t        ctl_br;
    op1_t       ctl_op1;
    op2_t       ctl_op2;
    imm_t       i_imm;
    imm_t       s_imm;
    imm_t       b_imm;
    imm_t       u_imm;
    imm_t       j_imm;
    word_t      rs1;
    word_t      rs2;
    word_t      op1;
    word_t      op2;
    logic       load;

    assign opcode   = in_inst[6:0];
    assign funct3   = in_inst[14:12];
    assign alt      = in_inst[30];
    assign rs1_addr = in_inst[19:15];
    assign rs2_addr = in_inst[24:20];

    assign i_imm = {{20{in_inst[31]}}, in_inst[31:20]};
    assign s_imm = {{20{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
    assign b_imm = {{19{in_inst[31]}}, in_inst[31], in_inst[7], in_inst[30:25],
                    in_inst[11:8], 1'b0};
    assign u_imm = {in_inst[31:12], 12'b0};
    assign j_imm = {{11{in_inst[31]}}, in_inst[31], in_inst[19:12], in_inst[20],
                    in_inst[30:21], 1'b0};

    // Control table
    always_comb begin
        ctl_op  = NONE;
        ctl_fn  = ADD;
        ctl_br  = NA;
        ctl_op1 = RS1;
        ctl_op2 = I_IMM;
        case (opcode)
            OPCODE_OP_IMM, OPCODE_OP: begin
                ctl_op  = INTEGER;
                ctl_op2 = (opcode == OPCODE_OP) ? RS2 : I_IMM;
                case (funct3)
                    F3_BEQ_LB_SB_ADD: ctl_fn = (opcode == OPCODE_OP && alt) ? SUB : ADD;
                    F3_BNE_LH_SH_SLL: ctl_fn = SLL;
                    F3_LW_SW_SLT:     ctl_fn = SLT;
                    F3_SLTU:          ctl_fn = SLTU;
                    F3_BLT_LBU_XOR:   ctl_fn = XOR;
                    F3_BGE_LHU_SR:    ctl_fn = alt ? SRA : SRL;
                    F3_BLTU_OR:       ctl_fn = OR;
                    default:          ctl_fn = AND;
                endcase
            end
            OPCODE_LUI: begin
                ctl_op  = INTEGER;
                ctl_fn  = OP2;
                ctl_op1 = XX;
                ctl_op2 = U_IMM;
            end
            OPCODE_AUIPC: begin
                ctl_op  = INTEGER;
                ctl_op1 = PC;
                ctl_op2 = U_IMM;
            end
            OPCODE_JAL: begin
                ctl_op  = JUMP;
                ctl_br  = JAL;
                ctl_op1 = PC;
                ctl_op2 = J_IMM;
            end
            OPCODE_JALR: begin
                ctl_op = JUMP;
                ctl_br = JAL;
            end
            OPCODE_BRANCH: begin
                ctl_op  = BRANCH;
                ctl_op1 = PC;
                ctl_op2 = B_IMM;
                case (funct3)
                    F3_BEQ_LB_SB_ADD: ctl_br = BEQ;
                    F3_BNE_LH_SH_SLL: ctl_br = BNE;
                    F3_BLT_LBU_XOR:   ctl_br = BLT;
                    F3_BGE_LHU_SR:    ctl_br = BGE;
                    F3_BLTU_OR:       ctl_br = BLTU;
                    F3_BGEU_AND:      ctl_br = BGEU;
                    default:          ctl_op = NONE;
                endcase
            end
            OPCODE_LOAD: begin
                case (funct3)
                    F3_LW_SW_SLT:     ctl_op = LOAD_WORD;
                    F3_BNE_LH_SH_SLL: ctl_op = LOAD_HALF;
                    F3_BGE_LHU_SR:    ctl_op = LOAD_HALF_UNSIGNED;
                    F3_BEQ_LB_SB_ADD: ctl_op = LOAD_BYTE;
                    F3_BLT_LBU_XOR:   ctl_op = LOAD_BYTE_UNSIGNED;
                    default:          ctl_op = NONE;
                endcase
            end
            OPCODE_STORE: begin
                ctl_op2 = S_IMM;
                case (funct3)
                    F3_LW_SW_SLT:     ctl_op = STORE_WORD;
                    F3_BNE_LH_SH_SLL: ctl_op = STORE_HALF;
                    F3_BEQ_LB_SB_ADD: ctl_op = STORE_BYTE;
                    default:          ctl_op = NONE;
                endcase
            end
            default: ctl_op = NONE;
        endcase
        // Unknown rows all look the same
        if (ctl_op == NONE) begin
            ctl_fn  = ANY;
            ctl_br  = NA;
            ctl_op1 = XX;
            ctl_op2 = RS2;
        end
    end

    // Forwarded source values
    always_comb begin
        case (rs1_sel)
            ALU:     rs1 = alu_data;
            EXE:     rs1 = exe_data;
            MEM:     rs1 = mem_data;
            default: rs1 = rs1_data;
        endcase
        case (rs2_sel)
            ALU:     rs2 = alu_data;
            EXE:     rs2 = exe_data;
            MEM:     rs2 = mem_data;
            default: rs2 = rs2_data;
        endcase
    end

    assign op1 = (ctl_op1 == PC) ? in_pc : rs1;

    always_comb begin
        case (ctl_op2)
            I_IMM:   op2 = i_imm;
            S_IMM:   op2 = s_imm;
            B_IMM:   op2 = b_imm;
            U_IMM:   op2 = u_imm;
            J_IMM:   op2 = j_imm;
            default: op2 = rs2;
        endcase
    end

    // Output register is free when empty or draining
    assign load     = !ex_valid || ex_ready;
    assign in_ready = load && !stall;
    assign invalid  = in_valid && ctl_op == NONE;

    always_ff @(posedge sink) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (load) begin
            ex_valid <= in_valid && !stall;
        end
    end

    always_ff @(posedge sink) begin
        if (load) begin
            ex_op  <= ctl_op;
            ex_fn  <= ctl_fn;
            ex_br  <= ctl_br;
            ex_pc  <= in_pc;
            ex_op1 <= op1;
            ex_op2 <= op2;
            ex_rs1 <= rs1;
            ex_rs2 <= rs2;
            ex_rd  <= in_inst[11:7];
        end
    end

    ex_hold: assert property (
        @(posedge sink) disable iff (reset)
        ex_valid && !ex_ready |=> ex_valid && $stable(ex_op) && $stable(ex_fn)
            && $stable(ex_br) && $stable(ex_pc) && $stable(ex_op1) && $stable(ex_op2)
            && $stable(ex_rs1) && $stable(ex_rs2) && $stable(ex_rd)
    ) else $error("decode: output changed under back-pressure");

    ex_reset: assert property (
        @(posedge sink) reset |=> !ex_valid
    ) else $error("decode: ex_valid high after reset");

endmodule

`default_nettype wire

// File: hw/forward_select.sv
`timescale 1ns/1ps
`default_nettype none

module forward_select
    import core_pkg::*;
(
    input  wire addr_t rs1_addr,
    input  wire addr_t rs2_addr,
    input  wire addr_t alu_rd,
    input  wire addr_t exe_rd,
    input  wire addr_t mem_rd,
    input  wire logic  alu_wen,
    input  wire logic  exe_wen,
    input  wire logic  mem_wen,
    input  wire logic  alu_load,
    output rs_t        rs1_sel,
    output rs_t        rs2_sel,
    output logic       stall
);

    // Nearest stage wins and x0 is never forwarded
    function automatic rs_t pick(addr_t rs);
        rs_t sel;
        sel = REG;
        if (rs != '0) begin
            if (alu_wen && alu_rd == rs) begin
                sel = ALU;
            end else if (exe_wen && exe_rd == rs) begin
                sel = EXE;
            end else if (mem_wen && mem_rd == rs) begin
                sel = MEM;
            end
        end
        return sel;
    endfunction

    always_comb begin
        rs1_sel = pick(rs1_addr);
        rs2_sel = pick(rs2_addr);
    end

    // Load data is not there until the next stage
    assign stall = alu_load && (rs1_sel == ALU || rs2_sel == ALU);

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
    import core_pkg::*;
(
    input  wire logic  sink,
    input  wire logic  reset,
    input  wire addr_t rs1_addr,
    input  wire addr_t rs2_addr,
    output word_t      rs1_data,
    output word_t      rs2_data,
    input  wire logic  wb_en,
    input  wire addr_t wb_addr,
    input  wire word_t wb_data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge sink) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // A same-cycle write still reads the old value
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    wb_addr_known: assert property (
        @(posedge sink) disable iff (reset)
        wb_en |-> !$isunknown(wb_addr)
    ) else $error("register_file: writeback address is unknown");

endmodule

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

    `include "rv32i_opcodes.svh"

    typedef logic [31:0] word_t;
    typedef logic [4:0]  addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] imm_t;

    // Operation class seen by execute and memory
    typedef enum logic [3:0] {
        NONE,
        INTEGER,
        JUMP,
        BRANCH,
        LOAD_WORD,
        LOAD_HALF,
        LOAD_HALF_UNSIGNED,
        LOAD_BYTE,
        LOAD_BYTE_UNSIGNED,
        STORE_WORD,
        STORE_HALF,
        STORE_BYTE
    } op_t;

    typedef enum logic [3:0] {
        ANY,
        ADD,
        SUB,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        OP2
    } fn_t;

    typedef enum logic [2:0] {
        NA,
        JAL,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } br_t;

    // XX means the operand is a don't care
    typedef enum logic [1:0] {
        RS1,
        PC,
        XX
    } op1_t;

    typedef enum logic [2:0] {
        RS2,
        I_IMM,
        S_IMM,
        B_IMM,
        U_IMM,
        J_IMM
    } op2_t;

    // Where a source register value comes from
    typedef enum logic [1:0] {
        REG,
        ALU,
        EXE,
        MEM
    } rs_t;

endpackage

`default_nettype wire

// File: include/rv32i_opcodes.svh
`ifndef RV32I_OPCODES_SVH
`define RV32I_OPCODES_SVH

// Major opcodes in bits 6:0 of the instruction
localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
localparam logic [6:0] OPCODE_OP     = 7'b0110011;
localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
localparam logic [6:0] OPCODE_STORE  = 7'b0100011;

// funct3 values shared between the formats
localparam logic [2:0] F3_BEQ_LB_SB_ADD = 3'b000;
localparam logic [2:0] F3_BNE_LH_SH_SLL  = 3'b001;
localparam logic [2:0] F3_LW_SW_SLT     = 3'b010;
localparam logic [2:0] F3_SLTU          = 3'b011;
localparam logic [2:0] F3_BLT_LBU_XOR   = 3'b100;
localparam logic [2:0] F3_BGE_LHU_SR    = 3'b101;
localparam logic [2:0] F3_BLTU_OR       = 3'b110;
localparam logic [2:0] F3_BGEU_AND      = 3'b111;

`endif
